// ==== src/pcie_rq_pkg.sv ====
package pcie_rq_pkg;

    // bus and field widths
    localparam int RQ_DATA_BITS = 512;
    localparam int RQ_KEEP_BITS = RQ_DATA_BITS / 32;  // one bit per dword
    localparam int TLP_HDR_BITS = 128;
    localparam int HOST_ADDR_BITS = 64;
    localparam int MMIO_ADDR_BITS = 40;
    localparam int MMIO_DATA_BITS = 64;
    localparam int REQ_TAG_BITS = 4;

    typedef logic [RQ_DATA_BITS-1:0] rq_data_t;
    typedef logic [RQ_KEEP_BITS-1:0] rq_keep_t;
    typedef logic [TLP_HDR_BITS-1:0] tlp_hdr_t;
    typedef logic [HOST_ADDR_BITS-1:0] host_addr_t;
    typedef logic [MMIO_ADDR_BITS-1:0] mmio_addr_t;
    typedef logic [MMIO_DATA_BITS-1:0] mmio_data_t;
    typedef logic [REQ_TAG_BITS-1:0] req_tag_t;

    // completer-request snoop
    localparam int CQ_ADDR_LSB = 128;  // base address field, 64 bits wide
    localparam host_addr_t BASE_SENTINEL = 64'h0000_0000_fefe_fefe;  // release base

    // window mapping
    localparam int MMIO_OFFSET_BITS = 24;

    // request TLP header fields
    localparam logic [3:0] REQ_MEM_READ = 4'd0;
    localparam logic [3:0] REQ_MEM_WRITE = 4'd1;
    localparam logic [10:0] REQ_DWORD_COUNT = 11'd2;  // one 64-bit word
    localparam logic [3:0] READ_TAG_PREFIX = 4'hf;

    // dword enables on the RQ beat
    localparam rq_keep_t KEEP_READ = 16'h000f;  // header only
    localparam rq_keep_t KEEP_WRITE = 16'h003f;  // header plus payload

    // completion data position
    localparam int RC_DATA_LSB = 96;

    // output FIFO sizing
    localparam int OUT_FIFO_ADDR_BITS = 5;
    localparam int OUT_FIFO_DEPTH = 1 << OUT_FIFO_ADDR_BITS;
    localparam int OUT_FIFO_HALF = OUT_FIFO_DEPTH / 2;  // back-pressure threshold

    // per-cycle request choice of the builder
    typedef enum logic [1:0] {
        REQ_NONE,
        REQ_READ,
        REQ_WRITE
    } req_kind_e;

endpackage

// ==== src/rq_tlp_if.sv ====
interface rq_tlp_if;
    import pcie_rq_pkg::*;

    rq_data_t beat;  // header, plus payload on writes
    rq_keep_t keep;
    logic valid;  // beat is taken whenever this is high
    logic last;
    logic is_write;  // entry will produce a write response

    modport src (
        output beat, keep, valid, last, is_write
    );

    modport dst (
        input beat, keep, valid, last, is_write
    );

endinterface

// ==== src/rq_base_capture.sv ====
module rq_base_capture (
    input  logic                    clk,
    input  logic                    rst,
    input  pcie_rq_pkg::rq_data_t   cq_tdata,
    input  logic                    cq_actv,
    output pcie_rq_pkg::host_addr_t host_base
);
    import pcie_rq_pkg::*;

    host_addr_t cq_addr;
    logic is_sentinel;
    logic locked;  // base held until released

    assign cq_addr = cq_tdata[CQ_ADDR_LSB +: HOST_ADDR_BITS];
    assign is_sentinel = (cq_addr == BASE_SENTINEL);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            host_base <= '0;
            locked <= 1'b0;
        end else if (cq_actv) begin
            if (is_sentinel) begin
                locked <= 1'b0;  // base kept, next beat reloads
            end else if (!locked) begin
                host_base <= cq_addr;
                locked <= 1'b1;
            end
        end
    end

endmodule

// ==== src/rq_req_builder.sv ====
module rq_req_builder (
    input  logic                    clk,
    input  logic                    rst,
    input  pcie_rq_pkg::host_addr_t host_base,
    input  pcie_rq_pkg::mmio_addr_t araddr,
    input  logic                    arvalid,
    output logic                    arready,
    input  pcie_rq_pkg::mmio_addr_t awaddr,
    input  logic                    awvalid,
    input  pcie_rq_pkg::mmio_data_t wdata,
    input  logic                    wvalid,
    output logic                    awready,
    output logic                    wready,
    input  logic                    space,
    rq_tlp_if.src                   tlp
);
    import pcie_rq_pkg::*;

    req_kind_e kind;
    req_tag_t tag;
    host_addr_t rd_addr;
    host_addr_t wr_addr;
    tlp_hdr_t rd_hdr;
    tlp_hdr_t wr_hdr;

    function automatic tlp_hdr_t make_hdr(
        input host_addr_t addr,
        input logic [3:0] req_type,
        input logic [7:0] hdr_tag
    );
        tlp_hdr_t hdr;
        hdr = '0;  // poison, IDs, TC, attr and ECRC all zero
        hdr[63:0] = addr;
        hdr[74:64] = REQ_DWORD_COUNT;
        hdr[78:75] = req_type;
        hdr[95:80] = 16'd0;  // requester ID
        hdr[103:96] = hdr_tag;
        hdr[119:104] = 16'd0;  // completer ID
        return hdr;
    endfunction

    // reads take priority, nothing is accepted without FIFO space
    always_comb begin
        kind = REQ_NONE;
        if (space) begin
            if (arvalid) begin
                kind = REQ_READ;
            end else if (awvalid && wvalid) begin
                kind = REQ_WRITE;
            end
        end
    end

    assign arready = (kind == REQ_READ);
    assign awready = (kind == REQ_WRITE);
    assign wready = (kind == REQ_WRITE);  // address and data go together

    // window offset added to the captured host base
    assign rd_addr = host_base + host_addr_t'(araddr[MMIO_OFFSET_BITS-1:0]);
    assign wr_addr = host_base + host_addr_t'(awaddr[MMIO_OFFSET_BITS-1:0]);

    assign rd_hdr = make_hdr(rd_addr, REQ_MEM_READ, {READ_TAG_PREFIX, tag});
    assign wr_hdr = make_hdr(wr_addr, REQ_MEM_WRITE, 8'd0);

    always_comb begin
        tlp.beat = '0;
        tlp.keep = '0;
        tlp.valid = 1'b0;
        tlp.is_write = 1'b0;
        case (kind)
            REQ_READ: begin
                tlp.beat = rq_data_t'(rd_hdr);
                tlp.keep = KEEP_READ;
                tlp.valid = 1'b1;
            end
            REQ_WRITE: begin
                tlp.beat = rq_data_t'({wdata, wr_hdr});  // payload at 191:128
                tlp.keep = KEEP_WRITE;
                tlp.valid = 1'b1;
                tlp.is_write = 1'b1;
            end
            default: begin
                tlp.valid = 1'b0;
            end
        endcase
    end

    assign tlp.last = 1'b1;  // every TLP fits one beat

    // rotating read tag, wraps 15 -> 0
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            tag <= '0;
        end else if (kind == REQ_READ) begin
            tag <= tag + req_tag_t'(1);
        end
    end

endmodule

// ==== src/rq_out_fifo.sv ====
module rq_out_fifo (
    input  logic                    clk,
    input  logic                    rst,
    rq_tlp_if.dst                   tlp,
    output logic                    space,
    output pcie_rq_pkg::rq_data_t   rq_tdata,
    output pcie_rq_pkg::rq_keep_t   rq_tkeep,
    output logic                    rq_tvalid,
    output logic                    rq_tlast,
    input  logic                    rq_tready,
    output logic                    bvalid,
    input  logic                    bready
);
    import pcie_rq_pkg::*;

    rq_data_t mem_data [OUT_FIFO_DEPTH];
    rq_keep_t mem_keep [OUT_FIFO_DEPTH];
    logic mem_last [OUT_FIFO_DEPTH];
    logic mem_write [OUT_FIFO_DEPTH];

    logic [OUT_FIFO_ADDR_BITS:0] wr_ptr;  // extra bit tells full from empty
    logic [OUT_FIFO_ADDR_BITS:0] rd_ptr;
    logic [OUT_FIFO_ADDR_BITS:0] count;
    logic full;
    logic empty;
    logic push;
    logic pop;
    logic half_full;

    assign count = wr_ptr - rd_ptr;
    assign full = (wr_ptr == (rd_ptr ^ {1'b1, {OUT_FIFO_ADDR_BITS{1'b0}}}));
    assign empty = (wr_ptr == rd_ptr);
    assign push = tlp.valid && !full;
    assign pop = !empty && (!rq_tvalid || rq_tready);  // output reg free or draining
    assign space = !half_full;

    always_ff @(posedge clk) begin
        if (push) begin
            mem_data[wr_ptr[OUT_FIFO_ADDR_BITS-1:0]] <= tlp.beat;
            mem_keep[wr_ptr[OUT_FIFO_ADDR_BITS-1:0]] <= tlp.keep;
            mem_last[wr_ptr[OUT_FIFO_ADDR_BITS-1:0]] <= tlp.last;
            mem_write[wr_ptr[OUT_FIFO_ADDR_BITS-1:0]] <= tlp.is_write;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            half_full <= 1'b0;
        end else begin
            half_full <= (count >= OUT_FIFO_HALF);  // one cycle late, slack covers it
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // output register, held while the link stalls
    always_ff @(posedge clk) begin
        if (pop) begin
            rq_tdata <= mem_data[rd_ptr[OUT_FIFO_ADDR_BITS-1:0]];
            rq_tkeep <= mem_keep[rd_ptr[OUT_FIFO_ADDR_BITS-1:0]];
            rq_tlast <= mem_last[rd_ptr[OUT_FIFO_ADDR_BITS-1:0]];
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rq_tvalid <= 1'b0;
            bvalid <= 1'b0;
        end else begin
            if (pop) begin
                rq_tvalid <= 1'b1;
            end else if (rq_tready) begin
                rq_tvalid <= 1'b0;
            end
            // write response level, set wins over bready
            if (pop && mem_write[rd_ptr[OUT_FIFO_ADDR_BITS-1:0]]) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

endmodule

// ==== src/rc_read_return.sv ====
module rc_read_return (
    input  logic                    clk,
    input  logic                    rst,
    input  pcie_rq_pkg::rq_data_t   rc_tdata,
    input  logic                    rc_tvalid,
    output pcie_rq_pkg::mmio_data_t rdata,
    output logic                    rvalid
);
    import pcie_rq_pkg::*;

    logic take;

    assign take = rc_tvalid && !rvalid;  // beat during the pulse is lost

    always_ff @(posedge clk) begin
        if (take) begin
            rdata <= rc_tdata[RC_DATA_LSB +: MMIO_DATA_BITS];
        end
    end

    // single-cycle pulse
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rvalid <= 1'b0;
        end else begin
            rvalid <= take;
        end
    end

endmodule

// ==== src/pcie_rq_adapter.sv ====
module pcie_rq_adapter (
    input  logic                    clk,
    input  logic                    rst,

    // completer-request snoop
    input  pcie_rq_pkg::rq_data_t   cq_tdata,
    input  logic                    cq_actv,

    // MMIO read address
    input  pcie_rq_pkg::mmio_addr_t araddr,
    input  logic                    arvalid,
    output logic                    arready,

    // MMIO write address and data
    input  pcie_rq_pkg::mmio_addr_t awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  pcie_rq_pkg::mmio_data_t wdata,
    input  logic                    wvalid,
    output logic                    wready,

    // write response
    output logic                    bvalid,
    input  logic                    bready,

    // read data
    output pcie_rq_pkg::mmio_data_t rdata,
    output logic                    rvalid,
    input  logic                    rready,

    // requester request
    output pcie_rq_pkg::rq_data_t   rq_tdata,
    output pcie_rq_pkg::rq_keep_t   rq_tkeep,
    output logic                    rq_tvalid,
    output logic                    rq_tlast,
    input  logic                    rq_tready,

    // requester completion
    input  pcie_rq_pkg::rq_data_t   rc_tdata,
    input  logic                    rc_tvalid,
    output logic                    rc_tready
);
    import pcie_rq_pkg::*;

    host_addr_t host_base;
    logic space;  // FIFO below half full

    rq_tlp_if tlp ();

    assign rc_tready = rready;  // completions follow the read-data ready

    rq_base_capture u_base (
        .clk       (clk),
        .rst       (rst),
        .cq_tdata  (cq_tdata),
        .cq_actv   (cq_actv),
        .host_base (host_base)
    );

    rq_req_builder u_builder (
        .clk       (clk),
        .rst       (rst),
        .host_base (host_base),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .wdata     (wdata),
        .wvalid    (wvalid),
        .awready   (awready),
        .wready    (wready),
        .space     (space),
        .tlp       (tlp.src)
    );

    rq_out_fifo u_fifo (
        .clk       (clk),
        .rst       (rst),
        .tlp       (tlp.dst),
        .space     (space),
        .rq_tdata  (rq_tdata),
        .rq_tkeep  (rq_tkeep),
        .rq_tvalid (rq_tvalid),
        .rq_tlast  (rq_tlast),
        .rq_tready (rq_tready),
        .bvalid    (bvalid),
        .bready    (bready)
    );

    rc_read_return u_return (
        .clk       (clk),
        .rst       (rst),
        .rc_tdata  (rc_tdata),
        .rc_tvalid (rc_tvalid),
        .rdata     (rdata),
        .rvalid    (rvalid)
    );

endmodule

// ==== test/tb_pcie_rq_adapter.sv ====
module tb_pcie_rq_adapter;
    timeunit 1ns;
    timeprecision 1ps;

    import pcie_rq_pkg::*;

    localparam int NUM_REQS = 400;
    localparam longint WATCHDOG_NS = longint'(NUM_REQS) * 40 * 20 + 20000;

    logic clk;
    logic rst;
    rq_data_t cq_tdata;
    logic cq_actv;
    mmio_addr_t araddr;
    logic arvalid;
    logic arready;
    mmio_addr_t awaddr;
    logic awvalid;
    logic awready;
    mmio_data_t wdata;
    logic wvalid;
    logic wready;
    logic bvalid;
    logic bready;
    mmio_data_t rdata;
    logic rvalid;
    logic rready;
    rq_data_t rq_tdata;
    rq_keep_t rq_tkeep;
    logic rq_tvalid;
    logic rq_tlast;
    logic rq_tready;
    rq_data_t rc_tdata;
    logic rc_tvalid;
    logic rc_tready;

    rq_data_t exp_data[$];  // expected TLPs in acceptance order
    rq_keep_t exp_keep[$];
    logic exp_write[$];
    host_addr_t model_base;
    logic model_locked;
    logic [3:0] model_tag;
    int accepted;
    int errors;
    int checks;
    int stall_left;
    int cycle;

    logic prev_tvalid;  // last cycle's view of the output side
    logic prev_tready;
    logic prev_bready;
    logic exp_bvalid;
    rq_data_t held_data;
    logic prev_rc_tvalid;
    mmio_data_t prev_rc_data;
    logic exp_rvalid;
    mmio_data_t exp_rdata;

    pcie_rq_adapter UUT (.*);

    always #10 clk = ~clk;

    task automatic check_equal(input rq_data_t actual, input rq_data_t expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    function automatic rq_data_t random_beat();
        rq_data_t beat;
        for (int i = 0; i < 16; i++) begin
            beat[i*32 +: 32] = $urandom;
        end
        return beat;
    endfunction

    // one-beat request TLP with header in 127:0 and payload in 191:128
    function automatic rq_data_t expected_tlp(input host_addr_t addr, input logic [3:0] req_type,
                                              input logic [7:0] tag8, input mmio_data_t payload);
        rq_data_t tlp;
        tlp = '0;
        tlp[63:0] = addr;
        tlp[74:64] = 11'd2;  // two dwords
        tlp[78:75] = req_type;
        tlp[103:96] = tag8;
        tlp[191:128] = payload;
        return tlp;
    endfunction

    task automatic drive_inputs(input bit offer);
        logic both;
        both = offer && ($urandom % 2 == 0);
        arvalid = offer && ($urandom % 2 == 0);
        araddr = mmio_addr_t'({$urandom, $urandom});
        awvalid = both || (offer && ($urandom % 8 == 0));  // sometimes address alone
        wvalid = both || (offer && ($urandom % 8 == 0));  // sometimes data alone
        awaddr = mmio_addr_t'({$urandom, $urandom});
        wdata = {$urandom, $urandom};
        cq_actv = offer && (cycle > 30) && ($urandom % 8 == 0);
        cq_tdata = random_beat();
        if ($urandom % 3 == 0) begin
            cq_tdata[128 +: 64] = 64'h0000_0000_fefe_fefe;
        end
        if (!offer) begin
            stall_left = 0;
            rq_tready = 1'b1;
        end else if (stall_left > 0) begin
            stall_left--;
            rq_tready = 1'b0;
        end else if ($urandom % 32 == 0) begin
            stall_left = 5 + int'($urandom % 40);  // long stall fills the FIFO
            rq_tready = 1'b0;
        end else begin
            rq_tready = ($urandom % 4 != 0);
        end
        bready = ($urandom % 2 == 0);
        rready = ($urandom % 2 == 0);
        rc_tvalid = ($urandom % 4 == 0);
        rc_tdata = random_beat();
    endtask

    task automatic take_requests();
        host_addr_t addr;
        // this few outstanding TLPs keep the FIFO well below half full
        if (exp_data.size() < 15) begin
            check_equal(rq_data_t'(arready), rq_data_t'(arvalid), "arready with FIFO space");
            if (!arvalid) begin
                check_equal(rq_data_t'(awready), rq_data_t'(awvalid && wvalid),
                            "awready with FIFO space");
            end
        end
        check_equal(rq_data_t'(wready), rq_data_t'(awready), "wready against awready");
        check_equal(rq_data_t'(arready && awready), '0, "read and write taken together");
        if (arvalid && awvalid && wvalid) begin
            check_equal(rq_data_t'(awready), '0, "awready while a read is offered");
        end
        if (arready) begin
            check_equal(rq_data_t'(arvalid), rq_data_t'(1'b1), "arready without arvalid");
            addr = model_base + host_addr_t'(araddr[23:0]);
            exp_data.push_back(expected_tlp(addr, 4'd0, {4'hf, model_tag}, '0));
            exp_keep.push_back(16'h000f);
            exp_write.push_back(1'b0);
            model_tag = model_tag + 4'd1;
            accepted++;
        end else if (awready) begin
            check_equal(rq_data_t'(awvalid && wvalid), rq_data_t'(1'b1),
                        "awready without awvalid and wvalid");
            addr = model_base + host_addr_t'(awaddr[23:0]);
            exp_data.push_back(expected_tlp(addr, 4'd1, 8'd0, wdata));
            exp_keep.push_back(16'h003f);
            exp_write.push_back(1'b1);
            accepted++;
        end
        if (cq_actv) begin  // new base counts from the next cycle
            if (cq_tdata[128 +: 64] == 64'h0000_0000_fefe_fefe) begin
                model_locked = 1'b0;
            end else if (!model_locked) begin
                model_base = cq_tdata[128 +: 64];
                model_locked = 1'b1;
            end
        end
    endtask

    task automatic monitor_outputs();
        logic new_beat;
        logic new_write;
        new_beat = rq_tvalid && (!prev_tvalid || prev_tready);
        new_write = 1'b0;
        if (new_beat) begin
            if (exp_data.size() == 0) begin
                errors++;
                $display("error at %0t ns: a TLP came out with none outstanding", $time);
            end else begin
                check_equal(rq_tdata, exp_data[0], "rq_tdata");
                check_equal(rq_data_t'(rq_tkeep), rq_data_t'(exp_keep[0]), "rq_tkeep");
                check_equal(rq_data_t'(rq_tlast), rq_data_t'(1'b1), "rq_tlast");
                new_write = exp_write[0];
            end
        end else if (prev_tvalid && !prev_tready) begin
            check_equal(rq_data_t'(rq_tvalid), rq_data_t'(1'b1), "rq_tvalid during stall");
            check_equal(rq_tdata, held_data, "rq_tdata during stall");
        end
        exp_bvalid = new_write || (exp_bvalid && !prev_bready);  // set beats clear
        check_equal(rq_data_t'(bvalid), rq_data_t'(exp_bvalid), "bvalid");
        if (rq_tvalid && rq_tready && exp_data.size() > 0) begin
            void'(exp_data.pop_front());
            void'(exp_keep.pop_front());
            void'(exp_write.pop_front());
        end
        if (prev_rc_tvalid && !exp_rvalid) begin
            exp_rvalid = 1'b1;
            exp_rdata = prev_rc_data;
        end else begin
            exp_rvalid = 1'b0;  // pulse lasts one cycle
        end
        check_equal(rq_data_t'(rvalid), rq_data_t'(exp_rvalid), "rvalid");
        if (exp_rvalid) begin
            check_equal(rq_data_t'(rdata), rq_data_t'(exp_rdata), "rdata");
        end
        check_equal(rq_data_t'(rc_tready), rq_data_t'(rready), "rc_tready");
        prev_tvalid = rq_tvalid;
        prev_tready = rq_tready;
        prev_bready = bready;
        held_data = rq_tdata;
        prev_rc_tvalid = rc_tvalid;
        prev_rc_data = rc_tdata[96 +: 64];
    endtask

    initial begin
        void'($urandom(70));
        clk = 1'b0;
        rst = 1'b0;
        cq_tdata = '0;
        cq_actv = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        rready = 1'b0;
        rq_tready = 1'b0;
        rc_tdata = '0;
        rc_tvalid = 1'b0;
        model_base = '0;
        model_locked = 1'b0;
        model_tag = '0;
        accepted = 0;
        errors = 0;
        checks = 0;
        stall_left = 0;
        cycle = 0;
        prev_tvalid = 1'b0;
        prev_tready = 1'b0;
        prev_bready = 1'b0;
        exp_bvalid = 1'b0;
        held_data = '0;
        prev_rc_tvalid = 1'b0;
        prev_rc_data = '0;
        exp_rvalid = 1'b0;
        exp_rdata = '0;
        repeat (5) @(negedge clk);
        rst = 1'b1;
        #1;
        check_equal(rq_data_t'(rq_tvalid), '0, "rq_tvalid after reset");
        check_equal(rq_data_t'(bvalid), '0, "bvalid after reset");
        check_equal(rq_data_t'(rvalid), '0, "rvalid after reset");
        while (accepted < NUM_REQS) begin
            @(negedge clk);
            drive_inputs(1'b1);
            #1;
            take_requests();
            monitor_outputs();
            cycle++;
        end
        while (exp_data.size() > 0 || rq_tvalid || bvalid) begin  // drain
            @(negedge clk);
            drive_inputs(1'b0);
            #1;
            take_requests();
            monitor_outputs();
        end
        $display("requests %0d, checks %0d, errors %0d", accepted, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("error: watchdog expired at %0t ns with %0d TLPs still expected",
                 $time, exp_data.size());
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// ==== vlog.f ====
src/pcie_rq_pkg.sv
src/rq_tlp_if.sv
src/rq_base_capture.sv
src/rq_req_builder.sv
src/rq_out_fifo.sv
src/rc_read_return.sv
src/pcie_rq_adapter.sv
test/tb_pcie_rq_adapter.sv

// ==== Makefile ====
TOP := tb_pcie_rq_adapter
BUILD := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f vlog.f --top-module $(TOP) -Mdir $(BUILD) -o sim
	./$(BUILD)/sim > sim.log 2>&1; cat sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf $(BUILD) sim.log
